// ==== sources.f ====
common/vic_pkg.sv
vic/vic_regs.sv
vic/vic_raster.sv
vic/vic_pixel.sv
hw/serial_tx.sv
hw/vic_top.sv
dv/tb_vic_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_vic_top -f sources.f \
    -Mdir obj_dir -o sim_tb

sim_out=$(./obj_dir/sim_tb)
echo "$sim_out"

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// ==== dv/tb_vic_top.sv ====
`timescale 1ns/100ps

module tb_vic_top;
    import vic_pkg::*;

    // own copy of the raster geometry
    localparam int HT = 64;
    localparam int VT = 48;
    localparam int FRAME = HT * VT;
    localparam int HS_W = 4;
    localparam int VS_W = 2;
    localparam int BIT_CYC = 4;  // clocks per serial bit

    // own copy of the colour table
    localparam rgb_t REF_PAL [16] = '{
        '{6'h00, 6'h00, 6'h00}, '{6'h3F, 6'h3F, 6'h3F}, '{6'h1A, 6'h0D, 6'h0A},
        '{6'h1C, 6'h29, 6'h2C}, '{6'h1B, 6'h0F, 6'h21}, '{6'h16, 6'h23, 6'h10},
        '{6'h0D, 6'h0A, 6'h1E}, '{6'h2E, 6'h31, 6'h1B}, '{6'h1B, 6'h13, 6'h09},
        '{6'h10, 6'h0E, 6'h00}, '{6'h26, 6'h19, 6'h16}, '{6'h11, 6'h11, 6'h11},
        '{6'h1B, 6'h1B, 6'h1B}, '{6'h26, 6'h34, 6'h21}, '{6'h1B, 6'h17, 6'h2D},
        '{6'h25, 6'h25, 6'h25}
    };

    typedef struct packed {
        logic       rd;     // 1 read, 0 write
        logic [5:0] addr;
        logic [7:0] wdata;
        logic [7:0] exp;
    } bus_op_t;

    logic sys_clock, rst_n, ce, rw, rx_busy;
    logic [5:0] adr;
    logic [7:0] dbi, dbo;
    logic irq, tx, hsync, vsync, active;
    logic [5:0] red, green, blue;
    rgb_t pix;

    int err_cnt = 0;
    int tmo_cnt = 0;
    logic [31:0] lcg_state = 32'd39325;
    logic [3:0] border_c, bg_c;
    logic [7:0] rx_bytes [$];  // bytes seen on the tx line
    bus_op_t stim [$];

    assign pix = '{red, green, blue};

    vic_top dut0 (
        .sys_clock(sys_clock), .rst_n(rst_n), .ce(ce), .rw(rw), .adr(adr), .dbi(dbi),
        .dbo(dbo), .irq(irq), .rx_busy(rx_busy), .tx(tx), .hsync(hsync), .vsync(vsync),
        .active(active), .red(red), .green(green), .blue(blue)
    );

    initial begin
        sys_clock = 1'b0;
        forever #4 sys_clock = ~sys_clock;
    end

    function automatic logic [7:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];  // upper bits spread better
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
        if (got !== exp) begin
            $display("Fail %0t: %s got %h expected %h", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string msg);
        if (got !== exp) begin
            $display("Fail %0t: %s got %h expected %h", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            $display("Fail %0t: %s got %b expected %b", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    task automatic bus_write(input logic [5:0] a, input logic [7:0] d);
        @(posedge sys_clock);
        ce  <= 1'b0;
        rw  <= 1'b0;
        adr <= a;
        dbi <= d;
        @(posedge sys_clock);  // write edge
        ce  <= 1'b1;
        rw  <= 1'b1;
    endtask

    task automatic bus_read(input logic [5:0] a, output logic [7:0] d);
        @(posedge sys_clock);
        ce  <= 1'b0;
        rw  <= 1'b1;
        adr <= a;
        @(posedge sys_clock);  // dbo loads here
        ce  <= 1'b1;
        @(negedge sys_clock);
        d = dbo;
    endtask

    task automatic wait_irq(input logic val, input int limit, input string what);
        int n;
        for (n = 0; n < limit && irq !== val; n++)
            @(negedge sys_clock);
        if (irq !== val) begin
            $display("Timeout: %s did not happen within %0d cycles", what, limit);
            tmo_cnt++;
        end
    endtask

    // read until the masked value matches
    task automatic poll_reg(input logic [5:0] a, input logic [7:0] mask, input logic [7:0] want,
                            input int limit, input string what);
        logic [7:0] d;
        int n;
        bus_read(a, d);
        for (n = 1; (d & mask) != want && n < limit; n++)
            bus_read(a, d);
        if ((d & mask) != want) begin
            $display("Timeout: %s did not show after %0d reads", what, limit);
            tmo_cnt++;
        end
    endtask

    task automatic wait_rx(input int limit, input string what);
        int n;
        for (n = 0; n < limit && rx_bytes.size() == 0; n++)
            @(negedge sys_clock);
        if (rx_bytes.size() == 0) begin
            $display("Timeout: %s never came out on tx", what);
            tmo_cnt++;
        end
    endtask

    // lock on vsync rising and check every pixel of one frame
    task automatic check_frame();
        logic hs_q, vs_q, rise, act, disp;
        int n, h_ref, v_ref;
        rgb_t want;
        @(negedge sys_clock);
        vs_q = vsync;
        n = 0;
        do begin
            @(negedge sys_clock);
            rise = vsync && !vs_q;
            vs_q = vsync;
            n++;
        end while (!rise && n < 2 * FRAME);
        if (!rise) begin
            $display("Timeout: no vsync rising edge seen");
            tmo_cnt++;
        end else begin
            h_ref = 0;
            v_ref = 0;
            hs_q = hsync;
            for (n = 0; n < FRAME; n++) begin
                if (n != 0) begin
                    @(negedge sys_clock);
                    if (hsync && !hs_q) begin  // new line
                        check_bit(h_ref == HT - 1, 1'b1, $sformatf("line %0d length", v_ref));
                        h_ref = 0;
                        v_ref++;
                    end else begin
                        h_ref++;
                    end
                    hs_q = hsync;
                end
                act  = h_ref >= 8 && h_ref < 56 && v_ref >= 4 && v_ref < 44;
                disp = h_ref >= 16 && h_ref < 48 && v_ref >= 12 && v_ref < 36;
                want = !act ? '0 : (disp ? REF_PAL[bg_c] : REF_PAL[border_c]);
                check_rgb(pix, want, $sformatf("rgb at h %0d v %0d", h_ref, v_ref));
                check_bit(active, act, $sformatf("active at h %0d v %0d", h_ref, v_ref));
                check_bit(hsync, h_ref < HS_W, $sformatf("hsync at h %0d", h_ref));
                check_bit(vsync, v_ref < VS_W, $sformatf("vsync at v %0d", v_ref));
            end
            @(negedge sys_clock);
            check_bit(vsync, 1'b1, "vsync back after one frame");
        end
    endtask

    task automatic irq_sequence(input irq_bit_e b, input string name);
        logic [7:0] mask, d;
        mask = 8'h01 << b;
        bus_write(REG_IRQ_STATUS, 8'h03);  // clean start
        bus_write(REG_IRQ_ENABLE, mask);
        wait_irq(1'b1, FRAME + 16, {name, " irq"});
        bus_read(REG_IRQ_STATUS, d);
        check_byte(d & mask, mask, {name, " status bit"});
        bus_write(REG_IRQ_STATUS, mask);   // w1c
        wait_irq(1'b0, 4, {name, " irq drop after clear"});
        bus_write(REG_IRQ_ENABLE, 8'h00);
        bus_write(REG_IRQ_STATUS, 8'h03);
        poll_reg(REG_IRQ_STATUS, mask, mask, FRAME / 2 + 8, {name, " status while masked"});
        repeat (2) @(negedge sys_clock);
        check_bit(irq, 1'b0, {name, " irq while masked"});
    endtask

    // serial line monitor sampling mid-bit
    initial begin
        logic [7:0] b;
        forever begin
            @(negedge sys_clock);
            if (rst_n === 1'b1 && tx === 1'b0) begin
                repeat (BIT_CYC / 2) @(negedge sys_clock);
                check_bit(tx, 1'b0, "start bit");
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYC) @(negedge sys_clock);
                    b[i] = tx;  // lsb first
                end
                repeat (BIT_CYC) @(negedge sys_clock);
                check_bit(tx, 1'b1, "stop bit");
                rx_bytes.push_back(b);
            end
        end
    end

    initial begin
        logic [7:0] d, b1, b2;
        ce = 1'b1;
        rw = 1'b1;
        adr = '0;
        dbi = '0;
        rx_busy = 1'b0;
        rst_n = 1'b0;
        repeat (5) @(posedge sys_clock);
        rst_n <= 1'b1;

        // register readback table
        b1 = next_rand();
        b2 = next_rand();
        if (b1[3:0] == b2[3:0])
            b2 = b2 ^ 8'h01;      // keep border and background apart
        border_c = b1[3:0];
        bg_c = b2[3:0];
        stim.push_back('{1'b0, REG_BORDER, b1, 8'h00});
        stim.push_back('{1'b0, REG_BACKGROUND, b2, 8'h00});
        stim.push_back('{1'b0, REG_IRQ_ENABLE, 8'hFF, 8'h00});
        stim.push_back('{1'b0, 6'h05, 8'hAA, 8'h00});   // unmapped
        stim.push_back('{1'b1, REG_BORDER, 8'h00, {4'h0, b1[3:0]}});
        stim.push_back('{1'b1, REG_BACKGROUND, 8'h00, {4'h0, b2[3:0]}});
        stim.push_back('{1'b1, REG_IRQ_ENABLE, 8'h00, 8'h03});
        stim.push_back('{1'b0, REG_IRQ_ENABLE, 8'h00, 8'h00});
        stim.push_back('{1'b1, REG_IRQ_ENABLE, 8'h00, 8'h00});
        stim.push_back('{1'b1, 6'h05, 8'h00, 8'h00});
        stim.push_back('{1'b1, 6'h3F, 8'h00, 8'h00});
        stim.push_back('{1'b1, REG_TX_DATA, 8'h00, 8'h00});
        stim.push_back('{1'b1, REG_LINK_STATUS, 8'h00, 8'h00});
        foreach (stim[i]) begin
            if (stim[i].rd) begin
                bus_read(stim[i].addr, d);
                check_byte(d, stim[i].exp, $sformatf("table read of 0x%02h", stim[i].addr));
            end else begin
                bus_write(stim[i].addr, stim[i].wdata);
            end
        end

        check_frame();
        repeat (6) begin
            bus_read(REG_RASTER, d);
            check_bit(d < VT, 1'b1, $sformatf("raster line %0d in range", d));
            repeat (next_rand()) @(posedge sys_clock);
        end

        bus_write(REG_RASTER, 8'd20);  // compare line
        irq_sequence(IRQ_RASTER, "raster");
        irq_sequence(IRQ_FRAME, "frame");

        // one byte on a free line
        b1 = next_rand();
        bus_write(REG_TX_DATA, b1);
        bus_read(REG_LINK_STATUS, d);
        check_byte(d, 8'h01, "link busy during transfer");
        wait_rx(12 * BIT_CYC, "serial byte");
        if (rx_bytes.size() != 0)
            check_byte(rx_bytes.pop_front(), b1, "received byte");
        poll_reg(REG_LINK_STATUS, 8'h01, 8'h00, 16, "link idle");

        // far end busy so the second write is dropped
        @(posedge sys_clock);
        rx_busy <= 1'b1;
        b1 = next_rand();
        b2 = ~b1;
        bus_write(REG_TX_DATA, b1);
        bus_read(REG_LINK_STATUS, d);
        check_byte(d, 8'h01, "link busy while held");
        bus_write(REG_TX_DATA, b2);
        repeat (8 * BIT_CYC) begin
            @(negedge sys_clock);
            check_bit(tx, 1'b1, "tx idle while held off");
        end
        check_bit(rx_bytes.size() == 0, 1'b1, "no byte while held off");
        @(posedge sys_clock);
        rx_busy <= 1'b0;
        wait_rx(12 * BIT_CYC, "held byte");
        if (rx_bytes.size() != 0)
            check_byte(rx_bytes.pop_front(), b1, "held byte");
        poll_reg(REG_LINK_STATUS, 8'h01, 8'h00, 16, "link idle after hold");
        repeat (12 * BIT_CYC) @(negedge sys_clock);
        check_bit(rx_bytes.size() == 0, 1'b1, "dropped byte stays dropped");

        $display("value errors %0d, timeouts %0d", err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== hw/vic_top.sv ====
`timescale 1ns/100ps

module vic_top (
    input  logic       sys_clock,
    input  logic       rst_n,
    input  logic       ce,       // low enables
    input  logic       rw,       // high reads
    input  logic [5:0] adr,
    input  logic [7:0] dbi,
    output logic [7:0] dbo,      // separate read path, no tristate
    output logic       irq,
    input  logic       rx_busy,  // link hold-off
    output logic       tx,
    output logic       hsync,
    output logic       vsync,
    output logic       active,
    output logic [5:0] red,
    output logic [5:0] green,
    output logic [5:0] blue
);
    import vic_pkg::*;

    bus_req_t    bus;
    vic_cfg_t    cfg;
    raster_pos_t pos;
    tx_req_t     tx_req;
    rgb_t        rgb;
    logic        tx_busy;

    assign bus = '{ce: ce, rw: rw, addr: adr, wdata: dbi};

    vic_regs regs0 (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .bus       (bus),
        .pos       (pos),
        .tx_busy   (tx_busy),
        .dbo       (dbo),
        .cfg       (cfg),
        .tx_req    (tx_req),
        .irq       (irq)
    );

    vic_raster raster0 (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .pos       (pos)
    );

    vic_pixel pixel0 (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .pos       (pos),
        .rgb       (rgb),
        .hsync     (hsync),
        .vsync     (vsync),
        .active    (active)
    );

    serial_tx tx0 (
        .sys_clock (sys_clock),
        .rst_n     (rst_n),
        .req       (tx_req),
        .rx_busy   (rx_busy),
        .tx        (tx),
        .busy      (tx_busy)
    );

    assign red   = rgb.red;
    assign green = rgb.green;
    assign blue  = rgb.blue;

endmodule

// ==== hw/serial_tx.sv ====
`timescale 1ns/100ps

module serial_tx (
    input  logic             sys_clock,
    input  logic             rst_n,
    input  vic_pkg::tx_req_t req,
    input  logic             rx_busy,
    output logic             tx,
    output logic             busy
);
    import vic_pkg::*;

    tx_state_e             state;
    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic [2:0]            bit_cnt;
    logic [7:0]            shreg;   // lsb goes out first
    logic                  baud_end;

    assign baud_end = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

    always_ff @(posedge sys_clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
        end else begin
            baud_cnt <= (state == TX_IDLE || baud_end) ? '0 : baud_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    if (!busy && req.valid)
                        busy <= 1'b1;           // byte pending
                    else if (busy && !rx_busy)
                        state <= TX_START;      // far end ready
                end
                TX_START: if (baud_end) begin
                    state   <= TX_DATA;
                    bit_cnt <= '0;
                end
                TX_DATA: if (baud_end) begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7)
                        state <= TX_STOP;
                end
                TX_STOP: if (baud_end) begin
                    state <= TX_IDLE;
                    busy  <= 1'b0;              // drops at end of stop bit
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge sys_clock) begin
        if (state == TX_IDLE && !busy && req.valid)
            shreg <= req.data;
        else if (state == TX_DATA && baud_end)
            shreg <= {1'b0, shreg[7:1]};
    end

    assign tx = (state == TX_START) ? 1'b0 :
                (state == TX_DATA)  ? shreg[0] : 1'b1;  // idle and stop high

    a_idle_line_high : assert property (
        @(posedge sys_clock) disable iff (!rst_n)
        !busy |-> tx
    ) else $error("tx low while serializer idle");

endmodule

// ==== vic/vic_pixel.sv ====
`timescale 1ns/100ps

module vic_pixel (
    input  logic                 sys_clock,
    input  logic                 rst_n,
    input  vic_pkg::vic_cfg_t    cfg,
    input  vic_pkg::raster_pos_t pos,
    output vic_pkg::rgb_t        rgb,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 active
);
    import vic_pkg::*;

    rgb_t pix_next;

    // blank, background or border
    always_comb begin
        if (!pos.active)
            pix_next = '0;
        else if (pos.display)
            pix_next = PALETTE[cfg.bg_color];
        else
            pix_next = PALETTE[cfg.border_color];
    end

    // colour and syncs share one stage so they stay lined up
    always_ff @(posedge sys_clock or negedge rst_n) begin
        if (!rst_n) begin
            rgb    <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            active <= 1'b0;
        end else begin
            rgb    <= pix_next;
            hsync  <= pos.hsync;
            vsync  <= pos.vsync;
            active <= pos.active;
        end
    end

endmodule

// ==== vic/vic_raster.sv ====
`timescale 1ns/100ps

module vic_raster (
    input  logic                 sys_clock,
    input  logic                 rst_n,
    input  vic_pkg::vic_cfg_t    cfg,
    output vic_pkg::raster_pos_t pos
);
    import vic_pkg::*;

    logic [7:0] h;
    logic [7:0] v;
    logic       h_last;
    logic       v_last;
    logic       act_h;
    logic       act_v;
    logic       disp_h;
    logic       disp_v;

    assign h_last = (h == H_TOTAL - 8'd1);
    assign v_last = (v == V_TOTAL - 8'd1);

    // h runs every cycle, v steps on the h wrap
    always_ff @(posedge sys_clock or negedge rst_n) begin
        if (!rst_n) begin
            h <= '0;
            v <= '0;
        end else if (h_last) begin
            h <= '0;
            v <= v_last ? 8'd0 : v + 8'd1;
        end else begin
            h <= h + 8'd1;
        end
    end

    // window decode, ends exclusive
    assign act_h  = (h >= ACTIVE_H_START) && (h < ACTIVE_H_END);
    assign act_v  = (v >= ACTIVE_V_START) && (v < ACTIVE_V_END);
    assign disp_h = (h >= DISP_H_START) && (h < DISP_H_END);
    assign disp_v = (v >= DISP_V_START) && (v < DISP_V_END);

    assign pos.h       = h;
    assign pos.v       = v;
    assign pos.hsync   = (h < HSYNC_LEN);
    assign pos.vsync   = (v < VSYNC_LEN);
    assign pos.active  = act_h & act_v;
    assign pos.display = disp_h & disp_v & act_h & act_v;  // display sits inside active

    // single compare point for the raster interrupt
    assign pos.raster_hit  = (h == 8'd0) && (v == cfg.raster_cmp);
    assign pos.frame_start = (h == 8'd0) && (v == 8'd0);

    a_h_in_range : assert property (
        @(posedge sys_clock) disable iff (!rst_n)
        h < H_TOTAL
    ) else $error("h counter past H_TOTAL");

endmodule

// ==== vic/vic_regs.sv ====
`timescale 1ns/100ps

module vic_regs (
    input  logic                sys_clock,
    input  logic                rst_n,
    input  vic_pkg::bus_req_t   bus,
    input  vic_pkg::raster_pos_t pos,
    input  logic                tx_busy,
    output logic [7:0]          dbo,
    output vic_pkg::vic_cfg_t   cfg,
    output vic_pkg::tx_req_t    tx_req,
    output logic                irq
);
    import vic_pkg::*;

    reg_addr_e  addr;
    logic       wr_en;
    logic       rd_en;
    logic [1:0] irq_status;
    logic [1:0] irq_en;
    logic [1:0] irq_set;
    logic [1:0] irq_clr;
    logic [1:0] irq_pend;
    logic [7:0] rd_data;

    assign addr  = reg_addr_e'(bus.addr);
    assign wr_en = ~bus.ce & ~bus.rw;  // write strobe
    assign rd_en = ~bus.ce & bus.rw;

    // new config value shows in cfg right after the write edge
    always_ff @(posedge sys_clock or negedge rst_n) begin
        if (!rst_n) begin
            cfg    <= '0;
            irq_en <= '0;
        end else if (wr_en) begin
            case (addr)
                REG_RASTER:     cfg.raster_cmp   <= bus.wdata;
                REG_BORDER:     cfg.border_color <= bus.wdata[3:0];
                REG_BACKGROUND: cfg.bg_color     <= bus.wdata[3:0];
                REG_IRQ_ENABLE: irq_en           <= bus.wdata[1:0];
                default: ;  // unmapped writes are dropped
            endcase
        end
    end

    always_comb begin
        irq_set             = '0;
        irq_set[IRQ_RASTER] = pos.raster_hit;
        irq_set[IRQ_FRAME]  = pos.frame_start;
    end

    assign irq_clr  = (wr_en && addr == REG_IRQ_STATUS) ? bus.wdata[1:0] : 2'b00;
    assign irq_pend = irq_status & irq_en;

    // w1c status where a set in the same cycle beats the clear
    always_ff @(posedge sys_clock or negedge rst_n) begin
        if (!rst_n) begin
            irq_status <= '0;
            irq         <= 1'b0;
        end else begin
            irq_status <= (irq_status & ~irq_clr) | irq_set;
            irq        <= |irq_pend;  // one cycle behind pend
        end
    end

    // byte goes straight to the serializer on the write edge
    assign tx_req.valid = wr_en && (addr == REG_TX_DATA) && !tx_busy;
    assign tx_req.data  = bus.wdata;

    always_comb begin
        case (addr)
            REG_RASTER:      rd_data = pos.v;  // live line rather than the compare value
            REG_IRQ_STATUS:  rd_data = {6'b0, irq_status};
            REG_IRQ_ENABLE:  rd_data = {6'b0, irq_en};
            REG_BORDER:      rd_data = {4'b0, cfg.border_color};
            REG_BACKGROUND:  rd_data = {4'b0, cfg.bg_color};
            REG_LINK_STATUS: rd_data = {7'b0, tx_busy};
            default:         rd_data = 8'h00;  // incl. tx data
        endcase
    end

    // read data holds until the next read
    always_ff @(posedge sys_clock or negedge rst_n) begin
        if (!rst_n)
            dbo <= 8'h00;
        else if (rd_en)
            dbo <= rd_data;
    end

    // status and enable only drop through a bus write
    // so without one an active irq needs an enabled pending bit
    a_irq_needs_pend : assert property (
        @(posedge sys_clock) disable iff (!rst_n)
        irq && !$past(wr_en) |-> |irq_pend
    ) else $error("irq high without enabled pending status");

endmodule

// ==== common/vic_pkg.sv ====
package vic_pkg;

    // raster geometry, all in sys_clock cycles / lines
    localparam logic [7:0] H_TOTAL        = 8'd64;
    localparam logic [7:0] V_TOTAL        = 8'd48;
    localparam logic [7:0] HSYNC_LEN      = 8'd4;   // from h == 0
    localparam logic [7:0] VSYNC_LEN      = 8'd2;   // from v == 0
    localparam logic [7:0] ACTIVE_H_START = 8'd8;
    localparam logic [7:0] ACTIVE_H_END   = 8'd56;  // exclusive
    localparam logic [7:0] ACTIVE_V_START = 8'd4;
    localparam logic [7:0] ACTIVE_V_END   = 8'd44;  // exclusive
    localparam logic [7:0] DISP_H_START   = 8'd16;
    localparam logic [7:0] DISP_H_END     = 8'd48;  // exclusive
    localparam logic [7:0] DISP_V_START   = 8'd12;
    localparam logic [7:0] DISP_V_END     = 8'd36;  // exclusive

    // serial link
    localparam int BAUD_DIV   = 4;                  // clocks per bit
    localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

    typedef enum logic [5:0] {
        REG_RASTER      = 6'h12,  // rd current line, wr compare
        REG_IRQ_STATUS  = 6'h19,  // write 1 to clear
        REG_IRQ_ENABLE  = 6'h1A,
        REG_BORDER      = 6'h20,
        REG_BACKGROUND  = 6'h21,
        REG_TX_DATA     = 6'h30,  // write only
        REG_LINK_STATUS = 6'h31   // bit 0 busy
    } reg_addr_e;

    typedef enum logic [0:0] {
        IRQ_RASTER = 1'b0,
        IRQ_FRAME  = 1'b1
    } irq_bit_e;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef struct packed {
        logic       ce;     // low enables
        logic       rw;     // high reads
        logic [5:0] addr;
        logic [7:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [3:0] border_color;
        logic [3:0] bg_color;
        logic [7:0] raster_cmp;
    } vic_cfg_t;

    typedef struct packed {
        logic [7:0] h;
        logic [7:0] v;
        logic       hsync;
        logic       vsync;
        logic       active;
        logic       display;
        logic       raster_hit;   // 1 cycle, h == 0 on compare line
        logic       frame_start;  // 1 cycle, h == 0 and v == 0
    } raster_pos_t;

    typedef struct packed {
        logic [5:0] red;
        logic [5:0] green;
        logic [5:0] blue;
    } rgb_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } tx_req_t;

    // classic 16 colour set, 6 bits per gun
    localparam rgb_t PALETTE [16] = '{
        '{6'h00, 6'h00, 6'h00},  // black
        '{6'h3F, 6'h3F, 6'h3F},  // white
        '{6'h1A, 6'h0D, 6'h0A},  // red
        '{6'h1C, 6'h29, 6'h2C},  // cyan
        '{6'h1B, 6'h0F, 6'h21},  // purple
        '{6'h16, 6'h23, 6'h10},  // green
        '{6'h0D, 6'h0A, 6'h1E},  // blue
        '{6'h2E, 6'h31, 6'h1B},  // yellow
        '{6'h1B, 6'h13, 6'h09},  // orange
        '{6'h10, 6'h0E, 6'h00},  // brown
        '{6'h26, 6'h19, 6'h16},  // light red
        '{6'h11, 6'h11, 6'h11},  // dark grey
        '{6'h1B, 6'h1B, 6'h1B},  // mid grey
        '{6'h26, 6'h34, 6'h21},  // light green
        '{6'h1B, 6'h17, 6'h2D},  // light blue
        '{6'h25, 6'h25, 6'h25}   // light grey
    };

endpackage
